//--- hdl/align_pkg.sv
`default_nettype none

package align_pkg;

  // user data word and stored word with parity on top.
  localparam int WIDTH   = 32;
  localparam int MEMWDTH = WIDTH + 1;

  // row geometry, three words per row.
  localparam int NUMWRDS = 3;
  localparam int BITWRDS = 2;
  localparam int NUMSROW = 80;
  localparam int BITSROW = 7;

  // logical address space.
  localparam int NUMADDR = 240;
  localparam int BITADDR = 8;
  localparam int BITPADR = BITWRDS + BITSROW;

  typedef struct packed {
    logic             par;
    logic [WIDTH-1:0] data;
  } mem_word_t;

  // one sram row, as raw bits or as word lanes.
  typedef union packed {
    logic [NUMWRDS*MEMWDTH-1:0] flat;
    mem_word_t [NUMWRDS-1:0]    lane;
  } mem_row_u;

  typedef struct packed {
    logic               write;
    logic               read;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
  } port_req_t;

  typedef struct packed {
    logic [WIDTH-1:0]   dout;
    logic               serr;
    logic [BITPADR-1:0] padr;
  } port_rsp_t;

  // lane sits above row, same order as padr.
  typedef struct packed {
    logic [BITWRDS-1:0] lane;
    logic [BITSROW-1:0] row;
  } phys_addr_t;

  typedef struct packed {
    logic               write;
    logic               read;
    logic [BITSROW-1:0] addr;
    mem_row_u           bw;
    mem_row_u           din;
  } sram_cmd_t;

endpackage

`default_nettype wire

//--- hdl/np2_addr.sv
`default_nettype none

module np2_addr import align_pkg::*; (
  input  logic [BITADDR-1:0] vaddr,
  output phys_addr_t         padr
);

  generate
    if ((1 << BITWRDS) == NUMWRDS) begin : g_pow2
      // power of two, plain bit slicing.
      assign padr.lane = vaddr[BITWRDS-1:0];
      assign padr.row  = BITSROW'(vaddr >> BITWRDS);
    end else begin : g_np2
      // general case, divide and remainder by the row size.
      assign padr.lane = BITWRDS'(vaddr % NUMWRDS);
      assign padr.row  = BITSROW'(vaddr / NUMWRDS);
    end
  endgenerate

endmodule

`default_nettype wire

//--- hdl/align_2rw.sv
`default_nettype none

module align_2rw import align_pkg::*; #(
  parameter int PARITY     = 1,
  parameter int SRAM_DELAY = 2,
  parameter int FLOPMEM    = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  port_req_t  req0,
  input  port_req_t  req1,
  input  phys_addr_t pa0,
  input  phys_addr_t pa1,
  output sram_cmd_t  cmd0,
  output sram_cmd_t  cmd1,
  input  mem_row_u   rdata0,
  input  mem_row_u   rdata1,
  output port_rsp_t  rsp0,
  output port_rsp_t  rsp1
);

  localparam int DEPTH = SRAM_DELAY + FLOPMEM;

  // what a read carries down the delay line.
  typedef struct packed {
    phys_addr_t       pa;
    logic             fwd;
    logic [WIDTH-1:0] word;
  } rd_tag_t;

  port_req_t  req   [2];
  phys_addr_t pa    [2];
  sram_cmd_t  cmd   [2];
  mem_row_u   rdata [2];
  port_rsp_t  rsp   [2];

  assign req[0]   = req0;
  assign req[1]   = req1;
  assign pa[0]    = pa0;
  assign pa[1]    = pa1;
  assign rdata[0] = rdata0;
  assign rdata[1] = rdata1;
  assign cmd0     = cmd[0];
  assign cmd1     = cmd[1];
  assign rsp0     = rsp[0];
  assign rsp1     = rsp[1];

  // merge buffer.
  logic               buf_vld;
  logic [BITSROW-1:0] buf_row;
  logic [NUMWRDS-1:0] buf_msk;
  mem_row_u           buf_dat;
  mem_row_u           buf_merge;

  mem_word_t          wrd      [2];
  logic [NUMWRDS-1:0] lane_msk [2];
  mem_row_u           lane_row [2];
  logic               hit      [2];
  logic               wr_hit   [2];
  logic               conf     [2];
  logic               same_row;
  logic               ww_same;
  logic               cw;

  function automatic mem_row_u put_word(mem_row_u row, logic [BITWRDS-1:0] idx,
                                        mem_word_t word);
    mem_row_u res;
    res = row;
    res.lane[idx] = word;
    return res;
  endfunction

  // one lane mask bit covers a whole stored word.
  function automatic mem_row_u expand_mask(logic [NUMWRDS-1:0] msk);
    mem_row_u res;
    for (int i = 0; i < NUMWRDS; i++) begin
      res.lane[i] = mem_word_t'({MEMWDTH{msk[i]}});
    end
    return res;
  endfunction

  always_comb begin
    same_row = pa[0].row == pa[1].row;
    ww_same  = req[0].write && req[1].write && same_row;
    for (int p = 0; p < 2; p++) begin
      wrd[p].par  = (PARITY != 0) && (^req[p].din);
      wrd[p].data = req[p].din;
      lane_msk[p] = '0;
      lane_msk[p][pa[p].lane] = 1'b1;
      lane_row[p] = put_word('0, pa[p].lane, wrd[p]);
      hit[p]      = buf_vld && (pa[p].row == buf_row);
      wr_hit[p]   = req[p].write && hit[p];
    end
    // write on one port against a read of the same row on the other.
    conf[0] = req[0].write && req[1].read && same_row;
    conf[1] = req[1].write && req[0].read && same_row;
    cw      = conf[1];
  end

  // port 1 merges last so it wins on a shared lane.
  always_comb begin
    buf_merge = buf_dat;
    if (wr_hit[0]) begin
      buf_merge.lane[pa[0].lane] = wrd[0];
    end
    if (wr_hit[1]) begin
      buf_merge.lane[pa[1].lane] = wrd[1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_vld <= 1'b0;
      buf_msk <= '0;
    end else if (conf[0] || conf[1]) begin
      buf_vld <= 1'b1;
      buf_row <= pa[cw].row;
      if (hit[cw]) begin
        buf_msk <= buf_msk | lane_msk[cw];
        buf_dat <= buf_merge;
      end else begin
        // old contents go out on this cycle's sram write.
        buf_msk <= lane_msk[cw];
        buf_dat <= lane_row[cw];
      end
    end else if (wr_hit[0] || wr_hit[1]) begin
      buf_msk <= buf_msk
                 | (wr_hit[0] ? lane_msk[0] : '0)
                 | (wr_hit[1] ? lane_msk[1] : '0);
      buf_dat <= buf_merge;
    end
  end

  // sram commands.
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      cmd[p].read  = req[p].read;
      cmd[p].write = req[p].write && !(conf[p] && (!buf_vld || hit[p]));
      cmd[p].addr  = conf[p] ? buf_row : pa[p].row;
      cmd[p].bw    = conf[p] ? expand_mask(buf_msk) : expand_mask(lane_msk[p]);
      cmd[p].din   = conf[p] ? buf_dat : lane_row[p];
    end
    // same-row writes travel together on port 1.
    if (ww_same) begin
      cmd[0].write = 1'b0;
      cmd[1].bw    = expand_mask(lane_msk[0] | lane_msk[1]);
      cmd[1].din   = put_word(lane_row[0], pa[1].lane, wrd[1]);
    end
  end

  // read delay line.
  rd_tag_t tag_in   [2];
  rd_tag_t tag_q    [2][DEPTH];
  rd_tag_t last_tag [2];

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      tag_in[p].pa   = pa[p];
      tag_in[p].fwd  = req[p].read && hit[p] && buf_msk[pa[p].lane];
      tag_in[p].word = buf_dat.lane[pa[p].lane].data;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      tag_q[p][0] <= tag_in[p];
      for (int s = 1; s < DEPTH; s++) begin
        tag_q[p][s] <= tag_q[p][s-1];
      end
    end
  end

  mem_row_u rd_row [2];

  generate
    if (FLOPMEM != 0) begin : g_flopmem
      always_ff @(posedge clk) begin
        rd_row[0] <= rdata[0];
        rd_row[1] <= rdata[1];
      end
    end else begin : g_noflopmem
      assign rd_row[0] = rdata[0];
      assign rd_row[1] = rdata[1];
    end
  endgenerate

  // lane select, parity check and physical address.
  mem_word_t raw [2];

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      last_tag[p]  = tag_q[p][DEPTH-1];
      raw[p]       = rd_row[p].lane[last_tag[p].pa.lane];
      rsp[p].dout  = last_tag[p].fwd ? last_tag[p].word : raw[p].data;
      rsp[p].serr  = (PARITY != 0) && !last_tag[p].fwd && (^raw[p]);
      rsp[p].padr  = last_tag[p].pa;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sram_2rw.sv
`default_nettype none

module sram_2rw import align_pkg::*; #(
  parameter int SRAM_DELAY = 2
) (
  input  logic      clk,
  input  sram_cmd_t cmd0,
  input  sram_cmd_t cmd1,
  output mem_row_u  rdata0,
  output mem_row_u  rdata1
);

  mem_row_u  mem [NUMSROW];
  sram_cmd_t cmd [2];
  mem_row_u  rd_pipe [2][SRAM_DELAY];
  logic      same_wr;

  assign cmd[0] = cmd0;
  assign cmd[1] = cmd1;

  // bit-masked update of one row.
  function automatic mem_row_u apply_write(mem_row_u old, sram_cmd_t c);
    mem_row_u res;
    res.flat = (old.flat & ~c.bw.flat) | (c.din.flat & c.bw.flat);
    return res;
  endfunction

  initial begin
    for (int r = 0; r < NUMSROW; r++) begin
      mem[r] = '0;
    end
  end

  assign same_wr = cmd[0].write && cmd[1].write && (cmd[0].addr == cmd[1].addr);

  // port 1 lands on top of port 0 for a shared row.
  always_ff @(posedge clk) begin
    if (cmd[0].write) begin
      mem[cmd[0].addr] <= apply_write(mem[cmd[0].addr], cmd[0]);
    end
    if (cmd[1].write) begin
      if (same_wr) begin
        mem[cmd[1].addr] <= apply_write(apply_write(mem[cmd[1].addr], cmd[0]), cmd[1]);
      end else begin
        mem[cmd[1].addr] <= apply_write(mem[cmd[1].addr], cmd[1]);
      end
    end
  end

  // array read sees the contents before this edge's writes.
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (cmd[p].read) begin
        rd_pipe[p][0] <= mem[cmd[p].addr];
      end
      for (int s = 1; s < SRAM_DELAY; s++) begin
        rd_pipe[p][s] <= rd_pipe[p][s-1];
      end
    end
  end

  assign rdata0 = rd_pipe[0][SRAM_DELAY-1];
  assign rdata1 = rd_pipe[1][SRAM_DELAY-1];

endmodule

`default_nettype wire

//--- hdl/mem_2rw_top.sv
`default_nettype none

module mem_2rw_top import align_pkg::*; #(
  parameter int PARITY     = 1,
  parameter int SRAM_DELAY = 2,
  parameter int FLOPMEM    = 0
) (
  input  logic      clk,
  input  logic      rst,
  input  port_req_t req0,
  input  port_req_t req1,
  output port_rsp_t rsp0,
  output port_rsp_t rsp1
);

  phys_addr_t pa0;
  phys_addr_t pa1;
  sram_cmd_t  cmd0;
  sram_cmd_t  cmd1;
  mem_row_u   rdata0;
  mem_row_u   rdata1;

  // address split, one per port.
  np2_addr i_np2_0 (
    .vaddr (req0.addr),
    .padr  (pa0)
  );

  np2_addr i_np2_1 (
    .vaddr (req1.addr),
    .padr  (pa1)
  );

  align_2rw #(
    .PARITY     (PARITY),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPMEM    (FLOPMEM)
  ) i_align_2rw (
    .clk    (clk),
    .rst    (rst),
    .req0   (req0),
    .req1   (req1),
    .pa0    (pa0),
    .pa1    (pa1),
    .cmd0   (cmd0),
    .cmd1   (cmd1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .rsp0   (rsp0),
    .rsp1   (rsp1)
  );

  sram_2rw #(
    .SRAM_DELAY (SRAM_DELAY)
  ) i_sram_2rw (
    .clk    (clk),
    .cmd0   (cmd0),
    .cmd1   (cmd1),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

endmodule

`default_nettype wire

//--- tests/mem_2rw_tb.sv
`default_nettype none

module mem_2rw_tb import align_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    RESET_CYCLES = 10;
  localparam int    ROW_WORDS    = 3;
  localparam int    READ_LATENCY = 2;
  localparam string STIM_FILE    = "tests/mem_2rw_input.txt";

  // one port's columns of a stimulus line.
  typedef struct packed {
    logic               write;
    logic               read;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
    logic [WIDTH-1:0]   exp_dout;
  } port_line_t;

  typedef struct packed {
    logic               read;
    logic [WIDTH-1:0]   dout;
    logic [BITPADR-1:0] padr;
  } expect_t;

  logic      clk;
  logic      rst;
  port_req_t req0;
  port_req_t req1;
  port_rsp_t rsp0;
  port_rsp_t rsp1;

  port_line_t stim0 [$];
  port_line_t stim1 [$];
  expect_t    exp_q0 [$];
  expect_t    exp_q1 [$];
  int         cycles = 0;
  int         cycle_limit;

  mem_2rw_top i_mem_2rw_top (
    .clk  (clk),
    .rst  (rst),
    .req0 (req0),
    .req1 (req1),
    .rsp0 (rsp0),
    .rsp1 (rsp1)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(string why);
    $display("Some tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  // lane is the remainder, row the quotient.
  function automatic logic [BITPADR-1:0] split_address(logic [BITADDR-1:0] a);
    logic [BITWRDS-1:0] lane;
    logic [BITSROW-1:0] row;
    lane = BITWRDS'(a % ROW_WORDS);
    row  = BITSROW'(a / ROW_WORDS);
    return {lane, row};
  endfunction

  function automatic port_line_t make_line(logic [31:0] w, logic [31:0] r, logic [31:0] a,
                                           logic [31:0] d, logic [31:0] e);
    port_line_t l;
    l.write    = w[0];
    l.read     = r[0];
    l.addr     = a[BITADDR-1:0];
    l.din      = d;
    l.exp_dout = e;
    return l;
  endfunction

  // din of a non-write cycle is noise.
  function automatic port_req_t to_request(port_line_t l);
    port_req_t r;
    r.write = l.write;
    r.read  = l.read;
    r.addr  = l.addr;
    r.din   = l.write ? l.din : $urandom;
    return r;
  endfunction

  function automatic expect_t to_expect(port_line_t l);
    expect_t e;
    e.read = l.read;
    e.dout = l.exp_dout;
    e.padr = split_address(l.addr);
    return e;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       text;
    logic [31:0] w0, r0, a0, d0, e0;
    logic [31:0] w1, r1, a1, d1, e1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file tests/mem_2rw_input.txt");
    end else begin
      while ($fgets(text, fd) != 0) begin
        // comment lines start with a slash.
        if (text.len() > 1 && text.getc(0) != "/") begin
          n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h",
                      w0, r0, a0, d0, e0, w1, r1, a1, d1, e1);
          if (n != 10) begin
            abort_run("stimulus file has a line without ten columns");
          end else begin
            stim0.push_back(make_line(w0, r0, a0, d0, e0));
            stim1.push_back(make_line(w1, r1, a1, d1, e1));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_port(string port, port_rsp_t rsp, expect_t e);
    if (e.read) begin
      check_value({port, ".dout"}, rsp.dout, e.dout);
      check_value({port, ".serr"}, 32'(rsp.serr), 32'h0);
      check_value({port, ".padr"}, 32'(rsp.padr), 32'(e.padr));
    end
  endtask

  // front of each queue is the read sampled two edges ago.
  task automatic check_responses();
    expect_t e;
    if (exp_q0.size() == READ_LATENCY) begin
      e = exp_q0.pop_front();
      check_port("rsp0", rsp0, e);
    end
    if (exp_q1.size() == READ_LATENCY) begin
      e = exp_q1.pop_front();
      check_port("rsp1", rsp1, e);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      abort_run("timeout: run did not finish");
    end
  end

  initial begin
    port_line_t idle;
    void'($urandom(32'h194d));
    rst  = 1'b1;
    req0 = '0;
    req1 = '0;
    idle = '0;
    load_stimulus();
    cycle_limit = stim0.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < stim0.size(); i++) begin
      @(posedge clk);
      req0 <= to_request(stim0[i]);
      req1 <= to_request(stim1[i]);
      @(negedge clk);
      check_responses();
      exp_q0.push_back(to_expect(stim0[i]));
      exp_q1.push_back(to_expect(stim1[i]));
    end
    // drain the reads still in flight.
    repeat (READ_LATENCY) begin
      @(posedge clk);
      req0 <= to_request(idle);
      req1 <= to_request(idle);
      @(negedge clk);
      check_responses();
      exp_q0.push_back(to_expect(idle));
      exp_q1.push_back(to_expect(idle));
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/mem_2rw_input.txt
// w0 r0 addr0 din0 exp_dout0  w1 r1 addr1 din1 exp_dout1, all hex, one line per cycle
// exp_dout is compared only where that port's read column is 1
1 0 10 11110010 00000000  1 0 20 22220020 00000000
1 0 11 11110011 00000000  1 0 21 22220021 00000000
1 0 12 11110012 00000000  1 0 22 22220022 00000000
0 1 10 00000000 11110010  0 1 20 00000000 22220020
0 1 11 00000000 11110011  0 1 21 00000000 22220021
0 1 22 00000000 22220022  0 1 12 00000000 11110012
0 1 20 00000000 22220020  0 1 10 00000000 11110010
1 0 30 33330030 00000000  0 1 30 00000000 00000000
0 0 00 00000000 00000000  0 1 30 00000000 33330030
0 1 30 00000000 33330030  1 0 30 44440030 00000000
0 1 30 00000000 44440030  0 1 31 00000000 00000000
1 0 3c 55550060 00000000  0 1 3e 00000000 00000000
1 0 3d 55550061 00000000  0 1 3c 00000000 55550060
1 0 3e 55550062 00000000  0 1 3d 00000000 55550061
0 1 3e 00000000 55550062  0 1 3c 00000000 55550060
0 1 30 00000000 44440030  1 0 3d 66660061 00000000
0 1 3d 00000000 66660061  0 1 30 00000000 44440030
0 1 4b 00000000 00000000  1 0 4c 77770076 00000000
0 1 3c 00000000 55550060  0 1 3e 00000000 55550062
0 1 3d 00000000 66660061  0 1 4c 00000000 77770076
1 0 5a 88880090 00000000  1 0 5b 99990091 00000000
0 1 5a 00000000 88880090  0 1 5b 00000000 99990091
1 0 5c aaaa0092 00000000  1 0 5c bbbb0092 00000000
0 1 5c 00000000 bbbb0092  0 1 5a 00000000 88880090
1 0 4c cccc0076 00000000  1 0 4c dddd0076 00000000
0 1 4c 00000000 dddd0076  0 1 4b 00000000 00000000
1 0 4b eeee0075 00000000  1 0 4d ffff0077 00000000
0 1 4d 00000000 ffff0077  0 1 4b 00000000 eeee0075
1 0 00 01234500 00000000  1 0 ef 0fedcba9 00000000
1 0 02 01234502 00000000  1 0 03 01234503 00000000
0 1 ef 00000000 0fedcba9  0 1 00 00000000 01234500
0 1 03 00000000 01234503  0 1 02 00000000 01234502
0 1 ee 00000000 00000000  0 1 01 00000000 00000000
0 1 ed 00000000 00000000  0 1 ef 00000000 0fedcba9
1 0 01 12340001 00000000  0 1 00 00000000 01234500
0 1 4c 00000000 dddd0076  0 1 01 00000000 12340001
0 1 4b 00000000 eeee0075  0 1 4d 00000000 ffff0077
0 1 02 00000000 01234502  1 0 00 56780000 00000000
0 1 00 00000000 56780000  0 1 01 00000000 12340001
0 0 00 00000000 00000000  0 0 00 00000000 00000000
0 1 10 00000000 11110010  0 0 00 00000000 00000000
0 0 00 00000000 00000000  0 1 5c 00000000 bbbb0092
1 0 10 aaaa0010 00000000  0 1 11 00000000 11110011
0 1 11 00000000 11110011  0 1 10 00000000 aaaa0010
0 1 00 00000000 56780000  0 1 01 00000000 12340001
0 1 0f 00000000 00000000  0 1 ef 00000000 0fedcba9

//--- vlog.f
hdl/align_pkg.sv
hdl/np2_addr.sv
hdl/align_2rw.sv
hdl/sram_2rw.sv
hdl/mem_2rw_top.sv
tests/mem_2rw_tb.sv

//--- Makefile
TOP := mem_2rw_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

obj_dir/V$(TOP): vlog.f $(wildcard hdl/*.sv) tests/mem_2rw_tb.sv
	verilator --binary --timing --top-module $(TOP) -f vlog.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
